// ==== files.f ====
rtl/aluPkg.sv
rtl/wbRegMapPkg.sv
rtl/carryLookahead16.sv
rtl/barrelShifter.sv
rtl/alu.sv
rtl/wbCommandRegs.sv
rtl/resultRegs.sv
rtl/aluCoprocessor.sv
testbench/tb_aluCoprocessor.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu import aluPkg::*; (
        input  operandWord        operandA,
        input  operandWord        operandB,
        input  aluOp              op,
        input  logic              invB,
        input  logic              sign,
        output logic [DATA_W-1:0] result,
        output logic              zero,
        output logic              carryOut,
        output logic              overflow,
        output logic              err
);

        logic [DATA_W-1:0] shiftOut;
        logic [DATA_W-1:0] sumOut;
        logic [DATA_W-1:0] negIn;
        logic [DATA_W-1:0] negOut;
        logic [DATA_W-1:0] addA;
        logic [DATA_W-1:0] addB;
        logic              addCarry;
        logic              addOfl;

        barrelShifter shifter_i (
                .shiftIn    (operandA.data),
                .shiftCount (operandB.shift.shiftCount),
                .direction  (op[1:0]),
                .shiftOut   (shiftOut)
        );

        // two's complement of the subtrahend
        assign negIn = (op == OP_SUBBA) ? ~operandA.data : ~operandB.data;

        carryLookahead16 negAdder_i (
                .a        (negIn),
                .b        (16'h0001),
                .carryIn  (1'b0),
                .sum      (negOut),
                .carryOut (),
                .overflow ()
        );

        assign addA = (op == OP_SUBBA) ? negOut : operandA.data;
        assign addB = (op == OP_SUBAB) ? negOut : operandB.data;

        carryLookahead16 mainAdder_i (
                .a        (addA),
                .b        (addB),
                .carryIn  (1'b0),
                .sum      (sumOut),
                .carryOut (addCarry),
                .overflow (addOfl)
        );

        always_comb begin
                result = '0;
                err    = 1'b0;
                case (op)
                        OP_ROL, OP_SLL, OP_ROR, OP_SRL: result = shiftOut;
                        OP_ADD, OP_SUBAB, OP_SUBBA:     result = sumOut;
                        OP_XOR: result = operandA.data ^ operandB.data;
                        OP_AND: result = invB ? (operandA.data & ~operandB.data)
                                              : (operandA.data & operandB.data);
                        default: err = 1'b1;  // ops 9 to 15
                endcase
        end

        assign zero     = ~(|result);
        assign carryOut = (op == OP_ADD || op == OP_SUBAB || op == OP_SUBBA) ? addCarry : 1'b0;
        assign overflow = (op == OP_ADD) ? (sign ? addOfl : addCarry) : 1'b0;

        always_comb begin
                errZeroResult: assert (!err || result == '0)
                        else $error("alu: err set with nonzero result %h", result);
        end

endmodule

// ==== rtl/aluCoprocessor.sv ====
`timescale 1ns/1ps

module aluCoprocessor import aluPkg::*; (
        input  logic              clk,
        input  logic              reset,
        input  logic              cyc,
        input  logic              stb,
        input  logic              we,
        input  logic [2:0]        adr,
        input  logic [DATA_W-1:0] datWr,
        output logic [DATA_W-1:0] datRd,
        output logic              ack
);

        operandWord        operandA;
        operandWord        operandB;
        aluOp              op;
        logic              invB;
        logic              sign;
        logic              go;
        logic [DATA_W-1:0] result;
        logic              zero;
        logic              carryOut;
        logic              overflow;
        logic              err;

        wbCommandRegs wbCommandRegs_i (
                .clk      (clk),
                .reset    (reset),
                .cyc      (cyc),
                .stb      (stb),
                .we       (we),
                .adr      (adr),
                .datWr    (datWr),
                .ack      (ack),
                .operandA (operandA),
                .operandB (operandB),
                .op       (op),
                .invB     (invB),
                .sign     (sign),
                .go       (go)
        );

        alu alu_i (
                .operandA (operandA),
                .operandB (operandB),
                .op       (op),
                .invB     (invB),
                .sign     (sign),
                .result   (result),
                .zero     (zero),
                .carryOut (carryOut),
                .overflow (overflow),
                .err      (err)
        );

        resultRegs resultRegs_i (
                .clk      (clk),
                .reset    (reset),
                .go       (go),
                .result   (result),
                .zero     (zero),
                .carryOut (carryOut),
                .overflow (overflow),
                .err      (err),
                .adr      (adr),
                .datRd    (datRd)
        );

endmodule

// ==== rtl/aluPkg.sv ====
package aluPkg;

        localparam int DATA_W = 16;

        typedef enum logic [3:0] {
                OP_ROL   = 4'd0,
                OP_SLL   = 4'd1,
                OP_ROR   = 4'd2,
                OP_SRL   = 4'd3,
                OP_ADD   = 4'd4,
                OP_XOR   = 4'd5,
                OP_AND   = 4'd6,  // and-not when invB set
                OP_SUBAB = 4'd7,  // A - B
                OP_SUBBA = 4'd8   // B - A
        } aluOp;

        // operand B doubles as the shift amount for ops 0 to 3
        typedef struct packed {
                logic [11:0] upperBits;  // ignored by the shifter
                logic [3:0]  shiftCount;
        } shiftView;

        typedef union packed {
                logic [DATA_W-1:0] data;
                shiftView          shift;
        } operandWord;

endpackage

// ==== rtl/barrelShifter.sv ====
`timescale 1ns/1ps

module barrelShifter (
        input  logic [15:0] shiftIn,
        input  logic [3:0]  shiftCount,
        input  logic [1:0]  direction,
        output logic [15:0] shiftOut
);

        logic [15:0] stage [0:4];

        assign stage[0] = shiftIn;

        // stage k moves by 2**k when shiftCount[k] is set
        genvar k;
        generate
                for (k = 0; k < 4; k++) begin : stg
                        localparam int N = 1 << k;

                        assign stage[k+1] = !shiftCount[k] ? stage[k] :
                                (direction == 2'd0) ? {stage[k][15-N:0], stage[k][15:16-N]} :
                                (direction == 2'd1) ? {stage[k][15-N:0], {N{1'b0}}} :
                                (direction == 2'd2) ? {stage[k][N-1:0], stage[k][15:N]} :
                                {{N{1'b0}}, stage[k][15:N]};  // logical right
                end
        endgenerate

        assign shiftOut = stage[4];

endmodule

// ==== rtl/carryLookahead16.sv ====
`timescale 1ns/1ps

module carryLookahead16 (
        input  logic [15:0] a,
        input  logic [15:0] b,
        input  logic        carryIn,
        output logic [15:0] sum,
        output logic        carryOut,
        output logic        overflow
);

        logic [15:0] p;
        logic [15:0] g;
        logic [3:0]  grpP;
        logic [3:0]  grpG;
        logic [4:0]  grpC;  // carry into each group
        logic [16:0] c;     // carry into each bit

        assign p = a ^ b;
        assign g = a & b;

        genvar i;
        generate
                for (i = 0; i < 4; i++) begin : grp
                        assign grpP[i] = &p[4*i+3 -: 4];
                        assign grpG[i] = g[4*i+3]
                                | (p[4*i+3] & g[4*i+2])
                                | (p[4*i+3] & p[4*i+2] & g[4*i+1])
                                | (p[4*i+3] & p[4*i+2] & p[4*i+1] & g[4*i]);

                        // carries inside the group
                        assign c[4*i]   = grpC[i];
                        assign c[4*i+1] = g[4*i] | (p[4*i] & grpC[i]);
                        assign c[4*i+2] = g[4*i+1] | (p[4*i+1] & g[4*i])
                                | (p[4*i+1] & p[4*i] & grpC[i]);
                        assign c[4*i+3] = g[4*i+2] | (p[4*i+2] & g[4*i+1])
                                | (p[4*i+2] & p[4*i+1] & g[4*i])
                                | (p[4*i+2] & p[4*i+1] & p[4*i] & grpC[i]);
                end
        endgenerate

        // second level lookahead
        assign grpC[0] = carryIn;
        assign grpC[1] = grpG[0] | (grpP[0] & carryIn);
        assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & carryIn);
        assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                | (grpP[2] & grpP[1] & grpP[0] & carryIn);
        assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                | (&grpP & carryIn);
        assign c[16] = grpC[4];

        assign sum      = p ^ c[15:0];
        assign carryOut = c[16];
        assign overflow = c[15] ^ c[16];  // signed overflow

endmodule

// ==== rtl/resultRegs.sv ====
`timescale 1ns/1ps

module resultRegs import aluPkg::*, wbRegMapPkg::*; (
        input  logic              clk,
        input  logic              reset,
        input  logic              go,
        input  logic [DATA_W-1:0] result,
        input  logic              zero,
        input  logic              carryOut,
        input  logic              overflow,
        input  logic              err,
        input  logic [2:0]        adr,
        output logic [DATA_W-1:0] datRd
);

        logic [DATA_W-1:0] resultQ;
        logic              zeroQ;
        logic              carryQ;
        logic              oflQ;
        logic              errQ;
        logic              captured;
        logic              done;

        always_ff @(posedge clk) begin
                if (reset) begin
                        resultQ  <= '0;
                        zeroQ    <= 1'b0;
                        carryQ   <= 1'b0;
                        oflQ     <= 1'b0;
                        errQ     <= 1'b0;
                        captured <= 1'b0;
                end else if (go) begin
                        resultQ  <= result;
                        zeroQ    <= zero;
                        carryQ   <= carryOut;
                        oflQ     <= overflow;
                        errQ     <= err;
                        captured <= 1'b1;
                end
        end

        assign done = captured && !go;  // low while a new op is in flight

        always_comb begin
                datRd = '0;
                case (regAddr'(adr))
                        ADDR_RESULT: datRd = resultQ;
                        ADDR_STATUS: begin
                                datRd[STAT_Z_BIT]    = zeroQ;
                                datRd[STAT_CO_BIT]   = carryQ;
                                datRd[STAT_OFL_BIT]  = oflQ;
                                datRd[STAT_ERR_BIT]  = errQ;
                                datRd[STAT_DONE_BIT] = done;
                        end
                        default: ;
                endcase
        end

        // done is back on the cycle after each launch
        doneAfterGo: assert property (@(posedge clk) disable iff (reset) go |=> done)
                else $error("resultRegs: done not set on the cycle after go");

endmodule

// ==== rtl/wbCommandRegs.sv ====
`timescale 1ns/1ps

module wbCommandRegs import aluPkg::*, wbRegMapPkg::*; (
        input  logic              clk,
        input  logic              reset,
        input  logic              cyc,
        input  logic              stb,
        input  logic              we,
        input  logic [2:0]        adr,
        input  logic [DATA_W-1:0] datWr,
        output logic              ack,
        output operandWord        operandA,
        output operandWord        operandB,
        output aluOp              op,
        output logic              invB,
        output logic              sign,
        output logic              go
);

        logic accept;

        assign accept = cyc && stb && !ack;  // one ack per strobe

        always_ff @(posedge clk) begin
                if (reset) begin
                        ack      <= 1'b0;
                        go       <= 1'b0;
                        operandA <= '0;
                        operandB <= '0;
                        op       <= OP_ROL;
                        invB     <= 1'b0;
                        sign     <= 1'b0;
                end else begin
                        ack <= accept;
                        go  <= accept && we && (regAddr'(adr) == ADDR_CMD);
                        if (accept && we) begin
                                case (regAddr'(adr))
                                        ADDR_OPA: operandA.data <= datWr;
                                        ADDR_OPB: operandB.data <= datWr;
                                        ADDR_CMD: begin
                                                op   <= aluOp'(datWr[CMD_OP_MSB:CMD_OP_LSB]);
                                                invB <= datWr[CMD_INVB_BIT];
                                                sign <= datWr[CMD_SIGN_BIT];
                                        end
                                        default: ;  // read-only or unmapped
                                endcase
                        end
                end
        end

        ackSingle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
                else $error("wbCommandRegs: ack held two cycles");

        goSingle: assert property (@(posedge clk) disable iff (reset) go |=> !go)
                else $error("wbCommandRegs: go held two cycles");

endmodule

// ==== rtl/wbRegMapPkg.sv ====
package wbRegMapPkg;

        typedef enum logic [2:0] {
                ADDR_OPA    = 3'd0,
                ADDR_OPB    = 3'd1,
                ADDR_CMD    = 3'd2,
                ADDR_RESULT = 3'd3,
                ADDR_STATUS = 3'd4
        } regAddr;

        // command word fields
        localparam int CMD_OP_LSB   = 0;
        localparam int CMD_OP_MSB   = 3;
        localparam int CMD_INVB_BIT = 4;
        localparam int CMD_SIGN_BIT = 5;

        // status word bits
        localparam int STAT_Z_BIT    = 0;
        localparam int STAT_CO_BIT   = 1;
        localparam int STAT_OFL_BIT  = 2;
        localparam int STAT_ERR_BIT  = 3;
        localparam int STAT_DONE_BIT = 4;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build and run from the project root so the vector file path resolves
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f --top-module tb_aluCoprocessor -o simAlu; then
        echo "Verilator build failed"
        exit 1
fi

output=$(./obj_dir/simAlu)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if echo "$output" | grep -q 'All tests passed!'; then
        exit 0
fi
exit 1

// ==== testbench/aluTests.txt ====
# op invB sign opA opB result Z CO Ofl err, all hex
# opB upper bits are junk on shift ops, only bits 3..0 count
0 0 0 8001 abc1 0003 0 0 0 0
0 0 0 1234 5a07 1a09 0 0 0 0
0 0 0 0001 ffff 8000 0 0 0 0
1 0 0 ffff 7770 ffff 0 0 0 0
1 0 0 1234 0f07 1a00 0 0 0 0
2 0 0 1234 0707 6824 0 0 0 0
2 0 0 8000 100f 0001 0 0 0 0
3 0 0 8001 ee01 4000 0 0 0 0
3 0 0 7fff ab0f 0000 1 0 0 0
4 0 0 ffff 0001 0000 1 1 1 0
4 0 1 ffff 0001 0000 1 1 0 0
4 0 1 7fff 0001 8000 0 0 1 0
4 0 0 7fff 0001 8000 0 0 0 0
7 0 0 0005 0003 0002 0 1 0 0
7 0 0 0003 0005 fffe 0 0 0 0
8 0 1 8000 0001 8001 0 0 0 0
8 0 0 0003 0005 0002 0 1 0 0
5 0 0 a5a5 a5a5 0000 1 0 0 0
6 0 0 f0f0 3c3c 3030 0 0 0 0
6 1 0 f0f0 3c3c c0c0 0 0 0 0
9 0 0 1234 5678 0000 1 0 0 1
f 1 1 ffff ffff 0000 1 0 0 1

// ==== testbench/tb_aluCoprocessor.sv ====
`timescale 1ns/1ps

module tb_aluCoprocessor import wbRegMapPkg::*; ();

        logic        clk;
        logic        reset;
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [15:0] datWr;
        logic [15:0] datRd;
        logic        ack;
        int          errors;
        int          vectors;
        logic        aborted;

        aluCoprocessor aluCoprocessor_i (.*);

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        task automatic checkValue(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
                valueMatch: assert (actual === expected)
                        else begin
                                errors++;
                                $display("CHECK FAILED at %0t: %s expected %h, got %h",
                                         $time, name, expected, actual);
                        end
        endtask

        task automatic endRun();
                $display("%0d vectors run, %0d errors", vectors, errors);
                if (errors == 0)
                        $display("All tests passed!");
                else
                        $display("Test failures found");
                $finish;
        endtask

        // one classic cycle driven and sampled 1 ns after the edge
        task automatic busAccess(input logic write, input logic [2:0] addr,
                                 input logic [15:0] wdata, output logic [15:0] rdata);
                int waited;
                waited = 0;
                repeat ($urandom % 4) @(posedge clk);  // idle gap
                @(posedge clk);
                #1;
                cyc   = 1'b1;
                stb   = 1'b1;
                we    = write;
                adr   = addr;
                datWr = wdata;
                do begin
                        @(posedge clk);
                        #1;
                        waited++;
                end while (!ack && waited < 20);
                rdata = datRd;
                cyc   = 1'b0;
                stb   = 1'b0;
                we    = 1'b0;
                if (!ack) begin
                        $display("timeout: no ack within 20 cycles for address %0d", addr);
                        errors++;
                        aborted = 1'b1;
                end else begin
                        @(posedge clk);
                        #1;
                        checkValue("ack", 16'd0, {15'd0, ack});  // ack gone after one cycle
                end
        endtask

        initial begin
                int          fd;
                int          n;
                string       line;
                logic [3:0]  op;
                logic        invB;
                logic        sign;
                logic        z;
                logic        co;
                logic        ofl;
                logic        err;
                logic [15:0] a;
                logic [15:0] b;
                logic [15:0] res;
                logic [15:0] rd;
                logic [15:0] lastRes;
                void'($urandom(32'hbd08));
                errors  = 0;
                vectors = 0;
                aborted = 1'b0;
                reset   = 1'b1;
                cyc     = 1'b0;
                stb     = 1'b0;
                we      = 1'b0;
                adr     = 3'd0;
                datWr   = 16'd0;
                lastRes = 16'd0;
                repeat (10) @(posedge clk);
                #1;
                reset = 1'b0;
                fd = $fopen("testbench/aluTests.txt", "r");
                if (fd == 0) begin
                        $display("could not open testbench/aluTests.txt");
                        errors++;
                end else begin
                        while (!aborted && $fgets(line, fd) != 0) begin
                                if (line.len() < 2 || line[0] == "#")
                                        continue;
                                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                                            op, invB, sign, a, b, res, z, co, ofl, err);
                                if (n != 10) begin
                                        $display("malformed vector line: %s", line);
                                        errors++;
                                        continue;
                                end
                                vectors++;
                                busAccess(1'b1, ADDR_OPA, a, rd);
                                busAccess(1'b1, ADDR_OPB, b, rd);
                                busAccess(1'b1, ADDR_CMD, {10'd0, sign, invB, op}, rd);
                                busAccess(1'b0, ADDR_RESULT, 16'd0, rd);
                                checkValue("result", res, rd);
                                busAccess(1'b0, ADDR_STATUS, 16'd0, rd);
                                checkValue("status", {11'd0, 1'b1, err, ofl, co, z}, rd);  // done set
                                lastRes = res;
                        end
                        $fclose(fd);
                end
                if (!aborted) begin
                        for (int i = 0; i < 8; i++) begin
                                if (i != ADDR_RESULT && i != ADDR_STATUS) begin
                                        busAccess(1'b0, 3'(i), 16'd0, rd);
                                        checkValue("datRd", 16'd0, rd);  // write-only or unmapped
                                end
                        end
                        busAccess(1'b1, ADDR_RESULT, ~lastRes, rd);
                        busAccess(1'b0, ADDR_RESULT, 16'd0, rd);
                        checkValue("result after write", lastRes, rd);
                end
                endRun();
        end

endmodule
